// ==== addrgen_top.f ====
+incdir+include
verilog/addrgen_pkg.sv
verilog/pe_req_intake.sv
verilog/axi_req_gen.sv
verilog/ls_req_queue.sv
verilog/addrgen_top.sv
sim/addrgen_top_asserts.sv
sim/addrgen_top_tb.sv

// ==== Makefile ====
# Verilator build and run of the address generator testbench

TOP       ?= addrgen_top_tb
SIM_DIR   ?= obj_dir
VERILATOR ?= verilator
LOG       ?= sim.log
FILELIST  ?= addrgen_top.f
PASS_MSG  ?= No errors
VFLAGS    ?= --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(SIM_DIR) -o V$(TOP)

run: build
	./$(SIM_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(SIM_DIR) $(LOG)

// ==== sim/addrgen_top_tb.sv ====
`include "addrgen_config.svh"

module addrgen_top_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import addrgen_pkg::*;

  localparam int          HALF_PERIOD = 50;
  localparam int          DRIVE_DELAY = 10;
  localparam int          TIMEOUT     = 4000;
  localparam logic [31:0] SEED        = 32'h06f1999b;
  localparam int          NUM_ROWS    = 10;

  // One sequencer instruction and whether it must be rejected
  typedef struct packed {
    mem_op_e op;
    addr_t   addr;
    vlen_t   vl;
    addr_t   stride;
    vew_e    vew;
    logic    err;
  } row_t;

  // Request word {is_load, size, len, addr}
  typedef logic [43:0] req_t;

  logic     clk_i;
  logic     rst_ni;
  logic     pe_req_valid_i;
  mem_op_e  pe_op_i;
  addr_t    pe_addr_i;
  vlen_t    pe_vl_i;
  addr_t    pe_stride_i;
  vew_e     pe_vew_i;
  logic     addrgen_ack_o;
  logic     addrgen_error_o;
  logic     ar_valid_o;
  logic     ar_ready_i;
  addr_t    ar_addr_o;
  ax_len_t  ar_len_o;
  ax_size_t ar_size_o;
  logic     aw_valid_o;
  logic     aw_ready_i;
  addr_t    aw_addr_o;
  ax_len_t  aw_len_o;
  ax_size_t aw_size_o;
  logic     ls_req_valid_o;
  logic     ls_req_ready_i;
  addr_t    ls_addr_o;
  ax_len_t  ls_len_o;
  ax_size_t ls_size_o;
  logic     ls_is_load_o;

  logic [31:0] lcg_state;
  // Requests still to appear on AXI, then on the queue outputs
  req_t        exp_axi_q [$];
  req_t        exp_ls_q [$];

  row_t rows [NUM_ROWS] = '{
    // Single aligned burst
    '{VLE,  32'h0000_1000, 16'd32,  32'h0000_0000, EW64, 1'b0},
    // More than 256 beats, split at the beat limit
    '{VLE,  32'h0000_2004, 16'd600, 32'h0000_0000, EW32, 1'b0},
    // Crosses the page at 0x4000
    '{VLE,  32'h0000_3f80, 16'd64,  32'h0000_0000, EW32, 1'b0},
    // Store behind loads, has to wait for the queue to drain
    '{VSE,  32'h0000_3f80, 16'd64,  32'h0000_0000, EW32, 1'b0},
    '{VSE,  32'h0000_7ff8, 16'd40,  32'h0000_0000, EW8,  1'b0},
    '{VLSE, 32'h0000_5000, 16'd8,   32'h0000_0040, EW16, 1'b0},
    '{VSSE, 32'h0000_6001, 16'd6,   32'h0000_0105, EW8,  1'b0},
    // Misaligned bases
    '{VLE,  32'h0000_0002, 16'd4,   32'h0000_0000, EW32, 1'b1},
    '{VSSE, 32'h0000_0007, 16'd3,   32'h0000_0010, EW16, 1'b1},
    // Negative stride walks down
    '{VLSE, 32'h0000_8000, 16'd5,   32'hffff_fff8, EW64, 1'b0}
  };

  addrgen_top addrgen_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #HALF_PERIOD clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  task automatic build_expected(input row_t r);
    addr_t a;
    addr_t start_al;
    addr_t last;
    addr_t limit;
    addr_t used;
    addr_t left;
    logic  is_load;
    is_load = (r.op == VLE) || (r.op == VLSE);
    if (r.err) return;
    if ((r.op == VLE) || (r.op == VSE)) begin
      a    = r.addr;
      left = addr_t'(r.vl);
      while (left != 0) begin
        start_al = a & ~addr_t'(`AXI_BYTES - 1);
        // End of the bus word that holds the last element
        last  = (a + (left << r.vew) - 1) | addr_t'(`AXI_BYTES - 1);
        limit = start_al + addr_t'(`MAX_BURST_BEATS * `AXI_BYTES) - 1;
        if (last > limit) last = limit;
        limit = a | addr_t'((1 << `PAGE_BITS) - 1);
        if (last > limit) last = limit;
        exp_axi_q.push_back({is_load, 3'(`AXI_SIZE_LOG), 8'((last - start_al) / `AXI_BYTES), a});
        used = (last - a + 1) >> r.vew;
        left = (left > used) ? left - used : 0;
        a    = last + 1;
      end
    end else begin
      for (int i = 0; i < int'(r.vl); i++) begin
        exp_axi_q.push_back({is_load, 3'(r.vew), 8'h00, r.addr + addr_t'(i) * r.stride});
      end
    end
  endtask

  ////////////////////
  // Monitor
  ////////////////////

  task automatic check_axi(input logic is_load, input addr_t addr, input ax_len_t len,
                           input ax_size_t size);
    req_t  want;
    string ch;
    ch = is_load ? "ar" : "aw";
    assert (exp_axi_q.size() != 0)
      else report_failure($sformatf("Unexpected transfer on the %s channel", ch));
    want = exp_axi_q.pop_front();
    assert (is_load == want[43])
      else report_failure($sformatf("ERROR %s_valid_o got 0x1 expected is_load 0x%h", ch, want[43]));
    assert (addr == want[31:0])
      else report_failure($sformatf("ERROR %s_addr_o got 0x%h expected 0x%h", ch, addr, want[31:0]));
    assert (len == want[39:32])
      else report_failure($sformatf("ERROR %s_len_o got 0x%h expected 0x%h", ch, len, want[39:32]));
    assert (size == want[42:40])
      else report_failure($sformatf("ERROR %s_size_o got 0x%h expected 0x%h", ch, size, want[42:40]));
    exp_ls_q.push_back(want);
  endtask

  task automatic check_pop();
    req_t want;
    assert (exp_ls_q.size() != 0) else report_failure("Queue popped with no request issued");
    want = exp_ls_q.pop_front();
    assert (ls_is_load_o == want[43])
      else report_failure($sformatf("ERROR ls_is_load_o got 0x%h expected 0x%h", ls_is_load_o, want[43]));
    assert (ls_addr_o == want[31:0])
      else report_failure($sformatf("ERROR ls_addr_o got 0x%h expected 0x%h", ls_addr_o, want[31:0]));
    assert (ls_len_o == want[39:32])
      else report_failure($sformatf("ERROR ls_len_o got 0x%h expected 0x%h", ls_len_o, want[39:32]));
    assert (ls_size_o == want[42:40])
      else report_failure($sformatf("ERROR ls_size_o got 0x%h expected 0x%h", ls_size_o, want[42:40]));
  endtask

  // Mid cycle, so valid and ready are settled for the coming edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (ar_valid_o && ar_ready_i) check_axi(1'b1, ar_addr_o, ar_len_o, ar_size_o);
      if (aw_valid_o && aw_ready_i) check_axi(1'b0, aw_addr_o, aw_len_o, aw_size_o);
      if (ls_req_valid_o && ls_req_ready_i) check_pop();
      // Direction must match the queue head
      assert (!(aw_valid_o && ls_req_valid_o && ls_is_load_o))
        else report_failure("Store request raised while a load is at the queue head");
      assert (!(ar_valid_o && ls_req_valid_o && !ls_is_load_o))
        else report_failure("Load request raised while a store is at the queue head");
    end
  end

  // Random back-pressure, AXI ready about three cycles in four
  initial begin
    lcg_state      = SEED;
    ar_ready_i     = 1'b0;
    aw_ready_i     = 1'b0;
    ls_req_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #(DRIVE_DELAY);
      lcg_state      = lcg_next(lcg_state);
      ar_ready_i     = |lcg_state[17:16];
      aw_ready_i     = |lcg_state[19:18];
      ls_req_ready_i = lcg_state[24];
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic run_row(input row_t r);
    int cycles;
    build_expected(r);
    pe_req_valid_i = 1'b1;
    pe_op_i        = r.op;
    pe_addr_i      = r.addr;
    pe_vl_i        = r.vl;
    pe_stride_i    = r.stride;
    pe_vew_i       = r.vew;
    cycles         = 0;
    while (!addrgen_ack_o) begin
      @(posedge clk_i);
      #(DRIVE_DELAY);
      cycles++;
      assert (cycles < TIMEOUT) else report_failure("Timed out waiting for addrgen_ack_o");
    end
    // Sequencer drops the request in the ack cycle
    pe_req_valid_i = 1'b0;
    assert (addrgen_error_o == r.err)
      else report_failure($sformatf("ERROR addrgen_error_o got 0x%h expected 0x%h",
                                    addrgen_error_o, r.err));
    assert (exp_axi_q.size() == 0)
      else report_failure("Instruction acknowledged before all requests were issued");
    @(posedge clk_i);
    #(DRIVE_DELAY);
    assert (!addrgen_ack_o) else report_failure("Acknowledge lasted more than one cycle");
  endtask

  task automatic drain_queue();
    int cycles;
    cycles = 0;
    while (exp_ls_q.size() != 0) begin
      @(posedge clk_i);
      #(DRIVE_DELAY);
      cycles++;
      assert (cycles < TIMEOUT) else report_failure("Timed out waiting for the queue to drain");
    end
    assert (!ls_req_valid_o)
      else report_failure($sformatf("ERROR ls_req_valid_o got 0x%h expected 0x0", ls_req_valid_o));
  endtask

  initial begin
    rst_ni         = 1'b0;
    pe_req_valid_i = 1'b0;
    pe_op_i        = OP_OTHER;
    pe_addr_i      = '0;
    pe_vl_i        = '0;
    pe_stride_i    = '0;
    pe_vew_i       = EW8;
    repeat (4) @(posedge clk_i);
    #(DRIVE_DELAY);
    rst_ni = 1'b1;
    assert (!(addrgen_ack_o || addrgen_error_o || ar_valid_o || aw_valid_o || ls_req_valid_o))
      else report_failure("Outputs not idle after reset");
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
    end
    drain_queue();
    $display("No errors");
    $finish;
  end

endmodule

// ==== sim/addrgen_top_asserts.sv ====
module addrgen_top_asserts (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  addrgen_ack_o,
  input logic                  addrgen_error_o,
  input logic                  ar_valid_o,
  input logic                  ar_ready_i,
  input addrgen_pkg::addr_t    ar_addr_o,
  input addrgen_pkg::ax_len_t  ar_len_o,
  input addrgen_pkg::ax_size_t ar_size_o,
  input logic                  aw_valid_o,
  input logic                  aw_ready_i,
  input addrgen_pkg::addr_t    aw_addr_o,
  input addrgen_pkg::ax_len_t  aw_len_o,
  input addrgen_pkg::ax_size_t aw_size_o,
  input logic                  ls_req_valid_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // One direction in flight at a time
  one_direction: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ar_valid_o && aw_valid_o))
    else $error("AR and AW valid high in the same cycle");

  // Requests wait with their fields held
  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable({ar_addr_o, ar_len_o, ar_size_o}))
    else $error("AR request changed before ar_ready_i");

  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable({aw_addr_o, aw_len_o, aw_size_o}))
    else $error("AW request changed before aw_ready_i");

  // A rejected instruction is acknowledged and puts nothing on the bus
  error_with_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    addrgen_error_o |-> addrgen_ack_o && !ar_valid_o && !aw_valid_o)
    else $error("addrgen_error_o high without addrgen_ack_o or with AXI traffic");

  // Quiet bus while reset is held
  idle_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !(ar_valid_o || aw_valid_o || ls_req_valid_o))
    else $error("Valid high during reset");

endmodule

bind addrgen_top addrgen_top_asserts addrgen_top_asserts_inst (.*);

// ==== verilog/addrgen_top.sv ====
module addrgen_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Sequencer
  input  logic                  pe_req_valid_i,
  input  addrgen_pkg::mem_op_e  pe_op_i,
  input  addrgen_pkg::addr_t    pe_addr_i,
  input  addrgen_pkg::vlen_t    pe_vl_i,
  input  addrgen_pkg::addr_t    pe_stride_i,
  input  addrgen_pkg::vew_e     pe_vew_i,
  output logic                  addrgen_ack_o,
  output logic                  addrgen_error_o,
  // AXI address channels
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output addrgen_pkg::addr_t    ar_addr_o,
  output addrgen_pkg::ax_len_t  ar_len_o,
  output addrgen_pkg::ax_size_t ar_size_o,
  output logic                  aw_valid_o,
  input  logic                  aw_ready_i,
  output addrgen_pkg::addr_t    aw_addr_o,
  output addrgen_pkg::ax_len_t  aw_len_o,
  output addrgen_pkg::ax_size_t aw_size_o,
  // Load/store units
  output logic                  ls_req_valid_o,
  input  logic                  ls_req_ready_i,
  output addrgen_pkg::addr_t    ls_addr_o,
  output addrgen_pkg::ax_len_t  ls_len_o,
  output addrgen_pkg::ax_size_t ls_size_o,
  output logic                  ls_is_load_o
);
  import addrgen_pkg::*;

  logic  gen_valid;
  addr_t gen_addr;
  vlen_t gen_len;
  addr_t gen_stride;
  vew_e  gen_vew;
  logic  gen_is_load;
  logic  gen_is_burst;
  logic  gen_done;
  logic  q_push;
  logic  q_full;
  logic  q_empty;
  logic  q_head_is_load;

  pe_req_intake pe_req_intake_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_op_i        (pe_op_i),
    .pe_addr_i      (pe_addr_i),
    .pe_vl_i        (pe_vl_i),
    .pe_stride_i    (pe_stride_i),
    .pe_vew_i       (pe_vew_i),
    .addrgen_ack_o  (addrgen_ack_o),
    .addrgen_error_o(addrgen_error_o),
    .gen_valid_o    (gen_valid),
    .gen_addr_o     (gen_addr),
    .gen_len_o      (gen_len),
    .gen_stride_o   (gen_stride),
    .gen_vew_o      (gen_vew),
    .gen_is_load_o  (gen_is_load),
    .gen_is_burst_o (gen_is_burst),
    .gen_done_i     (gen_done)
  );

  axi_req_gen axi_req_gen_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .gen_valid_i     (gen_valid),
    .gen_addr_i      (gen_addr),
    .gen_len_i       (gen_len),
    .gen_stride_i    (gen_stride),
    .gen_vew_i       (gen_vew),
    .gen_is_load_i   (gen_is_load),
    .gen_is_burst_i  (gen_is_burst),
    .gen_done_o      (gen_done),
    .ar_valid_o      (ar_valid_o),
    .ar_ready_i      (ar_ready_i),
    .ar_addr_o       (ar_addr_o),
    .ar_len_o        (ar_len_o),
    .ar_size_o       (ar_size_o),
    .aw_valid_o      (aw_valid_o),
    .aw_ready_i      (aw_ready_i),
    .aw_addr_o       (aw_addr_o),
    .aw_len_o        (aw_len_o),
    .aw_size_o       (aw_size_o),
    .q_push_o        (q_push),
    .q_full_i        (q_full),
    .q_empty_i       (q_empty),
    .q_head_is_load_i(q_head_is_load)
  );

  // AR and AW carry the same fields, and AR valid marks a load push
  ls_req_queue ls_req_queue_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .push_i        (q_push),
    .push_addr_i   (ar_addr_o),
    .push_len_i    (ar_len_o),
    .push_size_i   (ar_size_o),
    .push_is_load_i(ar_valid_o),
    .full_o        (q_full),
    .empty_o       (q_empty),
    .head_is_load_o(q_head_is_load),
    .ls_req_valid_o(ls_req_valid_o),
    .ls_req_ready_i(ls_req_ready_i),
    .ls_addr_o     (ls_addr_o),
    .ls_len_o      (ls_len_o),
    .ls_size_o     (ls_size_o),
    .ls_is_load_o  (ls_is_load_o)
  );

endmodule

// ==== verilog/ls_req_queue.sv ====
`include "addrgen_config.svh"

module ls_req_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Push side, one entry per AXI transfer
  input  logic                  push_i,
  input  addrgen_pkg::addr_t    push_addr_i,
  input  addrgen_pkg::ax_len_t  push_len_i,
  input  addrgen_pkg::ax_size_t push_size_i,
  input  logic                  push_is_load_i,
  output logic                  full_o,
  output logic                  empty_o,
  output logic                  head_is_load_o,
  // Load/store unit side
  output logic                  ls_req_valid_o,
  input  logic                  ls_req_ready_i,
  output addrgen_pkg::addr_t    ls_addr_o,
  output addrgen_pkg::ax_len_t  ls_len_o,
  output addrgen_pkg::ax_size_t ls_size_o,
  output logic                  ls_is_load_o
);
  import addrgen_pkg::*;

  localparam int unsigned DEPTH = `LS_QUEUE_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  addr_t            addr_mem [DEPTH];
  ax_len_t          len_mem  [DEPTH];
  ax_size_t         size_mem [DEPTH];
  logic             load_mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             pop;

  assign full_o  = (count_q == (PTR_W + 1)'(DEPTH));
  assign empty_o = (count_q == '0);
  assign pop     = ls_req_valid_o && ls_req_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      // Simultaneous push and pop leaves the count alone
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_mem[wr_ptr_q] <= push_addr_i;
      len_mem[wr_ptr_q]  <= push_len_i;
      size_mem[wr_ptr_q] <= push_size_i;
      load_mem[wr_ptr_q] <= push_is_load_i;
    end
  end

  // Head entry straight from the buffer
  assign ls_req_valid_o = !empty_o;
  assign ls_addr_o      = addr_mem[rd_ptr_q];
  assign ls_len_o       = len_mem[rd_ptr_q];
  assign ls_size_o      = size_mem[rd_ptr_q];
  assign ls_is_load_o   = load_mem[rd_ptr_q];
  assign head_is_load_o = load_mem[rd_ptr_q];

endmodule

// ==== verilog/axi_req_gen.sv ====
`include "addrgen_config.svh"

module axi_req_gen (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Instruction from the intake
  input  logic                  gen_valid_i,
  input  addrgen_pkg::addr_t    gen_addr_i,
  input  addrgen_pkg::vlen_t    gen_len_i,
  input  addrgen_pkg::addr_t    gen_stride_i,
  input  addrgen_pkg::vew_e     gen_vew_i,
  input  logic                  gen_is_load_i,
  input  logic                  gen_is_burst_i,
  output logic                  gen_done_o,
  // AR channel
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output addrgen_pkg::addr_t    ar_addr_o,
  output addrgen_pkg::ax_len_t  ar_len_o,
  output addrgen_pkg::ax_size_t ar_size_o,
  // AW channel
  output logic                  aw_valid_o,
  input  logic                  aw_ready_i,
  output addrgen_pkg::addr_t    aw_addr_o,
  output addrgen_pkg::ax_len_t  aw_len_o,
  output addrgen_pkg::ax_size_t aw_size_o,
  // Load/store queue status
  output logic                  q_push_o,
  input  logic                  q_full_i,
  input  logic                  q_empty_i,
  input  logic                  q_head_is_load_i
);
  import addrgen_pkg::*;

  typedef enum logic [1:0] {IDLE, PLAN, ISSUE} state_e;

  // Last byte of the next burst, from its start address and element count
  function automatic addr_t burst_end(addr_t a, vlen_t n, vew_e ew);
    addr_t start_al;
    addr_t cand;
    addr_t beat_cap;
    addr_t page_end;
    start_al = a & ~addr_t'(`AXI_BYTES - 1);
    // Round the last element byte up to the end of its bus word
    cand     = (a + (addr_t'(n) << ew) - addr_t'(1)) | addr_t'(`AXI_BYTES - 1);
    beat_cap = start_al + addr_t'(`MAX_BURST_BEATS * `AXI_BYTES - 1);
    page_end = a | addr_t'((1 << `PAGE_BITS) - 1);
    if (cand > beat_cap) cand = beat_cap;
    if (cand > page_end) cand = page_end;
    return cand;
  endfunction

  state_e   state_q;
  vlen_t    cnt_q;
  // Current request, no reset needed on the payload
  addr_t    addr_q;
  addr_t    stride_q;
  vew_e     vew_q;
  logic     is_load_q;
  logic     is_burst_q;
  addr_t    end_q;

  logic     issue_ok;
  logic     xfer;
  addr_t    start_al;
  addr_t    consumed;
  addr_t    addr_nxt;
  vlen_t    cnt_nxt;
  addr_t    plan_addr;
  vlen_t    plan_cnt;
  addr_t    end_nxt;
  ax_len_t  ax_len;
  ax_size_t ax_size;

  ////////////////////
  // Next request
  ////////////////////

  assign start_al = addr_q & ~addr_t'(`AXI_BYTES - 1);
  // Elements covered from the start address to the burst end
  assign consumed = (end_q - addr_q + addr_t'(1)) >> vew_q;

  always_comb begin
    if (is_burst_q) begin
      addr_nxt = end_q + addr_t'(1);
      // Last burst may run past the final element
      cnt_nxt  = (addr_t'(cnt_q) > consumed) ? cnt_q - vlen_t'(consumed) : '0;
    end else begin
      addr_nxt = addr_q + stride_q;
      cnt_nxt  = cnt_q - vlen_t'(1);
    end
  end

  // One end calculator, fed by the fresh request or by the one after a transfer
  assign plan_addr = (state_q == PLAN) ? addr_q : addr_nxt;
  assign plan_cnt  = (state_q == PLAN) ? cnt_q : cnt_nxt;
  assign end_nxt   = burst_end(plan_addr, plan_cnt, vew_q);

  ////////////////////
  // AXI handshake
  ////////////////////

  // Never mix directions in the queue, so responses come back in order
  assign issue_ok = (state_q == ISSUE) && !q_full_i &&
                    (q_empty_i || (q_head_is_load_i == is_load_q));

  assign ar_valid_o = issue_ok && is_load_q;
  assign aw_valid_o = issue_ok && !is_load_q;
  assign xfer       = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);
  assign q_push_o   = xfer;

  // Empty instruction finishes straight from PLAN
  assign gen_done_o = (xfer && (cnt_nxt == '0)) || ((state_q == PLAN) && (cnt_q == '0));

  assign ax_len  = is_burst_q ? ax_len_t'((end_q - start_al) >> `AXI_SIZE_LOG) : '0;
  assign ax_size = is_burst_q ? ax_size_t'(`AXI_SIZE_LOG) : ax_size_t'(vew_q);

  assign ar_addr_o = addr_q;
  assign ar_len_o  = ax_len;
  assign ar_size_o = ax_size;
  assign aw_addr_o = addr_q;
  assign aw_len_o  = ax_len;
  assign aw_size_o = ax_size;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (gen_valid_i) begin
            cnt_q   <= gen_len_i;
            state_q <= PLAN;
          end
        end
        PLAN: state_q <= (cnt_q == '0) ? IDLE : ISSUE;
        ISSUE: begin
          if (xfer) begin
            cnt_q <= cnt_nxt;
            if (cnt_nxt == '0) state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && gen_valid_i) begin
      addr_q     <= gen_addr_i;
      stride_q   <= gen_stride_i;
      vew_q      <= gen_vew_i;
      is_load_q  <= gen_is_load_i;
      is_burst_q <= gen_is_burst_i;
    end else if (xfer) begin
      addr_q <= addr_nxt;
    end
    // Burst end is registered so back to back bursts need no extra cycle
    if ((state_q == PLAN) || xfer) end_q <= end_nxt;
  end

endmodule

// ==== verilog/pe_req_intake.sv ====
module pe_req_intake (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Sequencer side
  input  logic                 pe_req_valid_i,
  input  addrgen_pkg::mem_op_e pe_op_i,
  input  addrgen_pkg::addr_t   pe_addr_i,
  input  addrgen_pkg::vlen_t   pe_vl_i,
  input  addrgen_pkg::addr_t   pe_stride_i,
  input  addrgen_pkg::vew_e    pe_vew_i,
  output logic                 addrgen_ack_o,
  output logic                 addrgen_error_o,
  // Generator side
  output logic                 gen_valid_o,
  output addrgen_pkg::addr_t   gen_addr_o,
  output addrgen_pkg::vlen_t   gen_len_o,
  output addrgen_pkg::addr_t   gen_stride_o,
  output addrgen_pkg::vew_e    gen_vew_o,
  output logic                 gen_is_load_o,
  output logic                 gen_is_burst_o,
  input  logic                 gen_done_i
);
  import addrgen_pkg::*;

  typedef enum logic [1:0] {IDLE, CHECK, BUSY} state_e;

  state_e  state_q, state_d;
  logic    ack_q, ack_d;
  logic    capture;
  logic    misaligned;
  // Registered copy of the instruction
  mem_op_e op_q;
  addr_t   addr_q;
  vlen_t   vl_q;
  addr_t   stride_q;
  vew_e    vew_q;

  // Only memory operations are taken, everything else is left to other units
  assign capture = (state_q == IDLE) && pe_req_valid_i &&
                   (pe_op_i inside {VLE, VSE, VLSE, VSSE});

  // Base must be a multiple of the element size
  assign misaligned = |(addr_q & ((addr_t'(1) << vew_q) - addr_t'(1)));

  always_comb begin
    state_d = state_q;
    ack_d   = 1'b0;
    case (state_q)
      IDLE: begin
        if (capture) state_d = CHECK;
      end
      // Error path acknowledges right here, no AXI traffic
      CHECK: state_d = misaligned ? IDLE : BUSY;
      BUSY: begin
        if (gen_done_i) ack_d = 1'b1;
        // Stay one more cycle so the acked request is not taken twice
        if (ack_q) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= ack_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      op_q     <= pe_op_i;
      addr_q   <= pe_addr_i;
      vl_q     <= pe_vl_i;
      stride_q <= pe_stride_i;
      vew_q    <= pe_vew_i;
    end
  end

  // Held from the check cycle until the generator reports done
  assign gen_valid_o    = ((state_q == CHECK) && !misaligned) || ((state_q == BUSY) && !ack_q);
  assign gen_addr_o     = addr_q;
  assign gen_len_o      = vl_q;
  assign gen_stride_o   = stride_q;
  assign gen_vew_o      = vew_q;
  assign gen_is_load_o  = op_q inside {VLE, VLSE};
  // Unit stride maps onto INCR bursts
  assign gen_is_burst_o = op_q inside {VLE, VSE};

  assign addrgen_error_o = (state_q == CHECK) && misaligned;
  assign addrgen_ack_o   = ack_q || addrgen_error_o;

endmodule

// ==== verilog/addrgen_pkg.sv ====
package addrgen_pkg;

  `include "addrgen_config.svh"

  // Byte address on the memory bus
  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  // Number of elements still to be requested
  typedef logic [`VL_WIDTH-1:0] vlen_t;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Sequencer operation, only the first four touch memory
  typedef enum logic [2:0] {
    VLE      = 3'd0,
    VSE      = 3'd1,
    VLSE     = 3'd2,
    VSSE     = 3'd3,
    OP_OTHER = 3'd4
  } mem_op_e;

  // AXI length (beats minus one) and size fields
  typedef logic [7:0] ax_len_t;
  typedef logic [2:0] ax_size_t;

endpackage

// ==== include/addrgen_config.svh ====
`ifndef ADDRGEN_CONFIG_SVH
`define ADDRGEN_CONFIG_SVH

// Address bits on the AXI side
`define ADDR_WIDTH 32

// Data beat of the AXI bus, in bytes
`define AXI_BYTES 8
// log2 of the beat size, also the burst size field
`define AXI_SIZE_LOG 3

// Element count of one vector instruction
`define VL_WIDTH 16

// Entries of the load/store request queue
`define LS_QUEUE_DEPTH 4

// AXI4 INCR bursts stop at 256 beats
`define MAX_BURST_BEATS 256
// Bursts never cross a 4 KiB page
`define PAGE_BITS 12

`endif
